// File: src/lsq_defs.svh
`ifndef LSQ_DEFS_SVH
`define LSQ_DEFS_SVH

// entries per queue, loads and stores each
`define LSQ_DEPTH 4

// rob index and operand tag width
`define ROB_IDX_W 5

// data and address width
`define XLEN 32

// data memory size in words
`define DMEM_WORDS 64

// wait states per apb access
`define DMEM_WAIT 1

`endif

// File: src/lsq_pkg.sv
`include "lsq_defs.svh"

package lsq_pkg;

    typedef enum logic {
        MEM_LOAD  = 1'b0,
        MEM_STORE = 1'b1
    } mem_op_e;

    typedef enum logic [1:0] {
        MU_IDLE   = 2'd0,
        MU_SETUP  = 2'd1,
        MU_ACCESS = 2'd2,
        MU_RESULT = 2'd3
    } mu_state_e;

    // wide enough to count every store in the queue
    localparam int OS_W = $clog2(`LSQ_DEPTH + 1);

    typedef struct packed {
        logic                  valid;
        mem_op_e               op;
        logic [`ROB_IDX_W-1:0] rob_idx;
        // base operand
        logic [`ROB_IDX_W-1:0] rs1_tag;
        logic                  rs1_ready;
        logic [`XLEN-1:0]      rs1_data;
        // store data operand
        logic [`ROB_IDX_W-1:0] rs2_tag;
        logic                  rs2_ready;
        logic [`XLEN-1:0]      rs2_data;
        logic [`XLEN-1:0]      imm;
        // stores only
        logic                  committed;
        // loads only
        logic [OS_W-1:0]       older_stores;
        logic                  issued;
    } lsq_entry_t;

endpackage

// File: src/cdb_if.sv
`timescale 1ns/100ps
`include "lsq_defs.svh"

interface cdb_if;

    // external producer, alu and multiplier
    logic                  ext_valid;
    logic [`ROB_IDX_W-1:0] ext_rob_idx;
    logic [`XLEN-1:0]      ext_data;

    // load results from the memory unit
    logic                  mem_valid;
    logic [`ROB_IDX_W-1:0] mem_rob_idx;
    logic [`XLEN-1:0]      mem_data;

    logic                  flush;

    modport mem_src (
        output mem_valid, mem_rob_idx, mem_data,
        input  flush
    );

    modport listener (
        input ext_valid, ext_rob_idx, ext_data,
        input mem_valid, mem_rob_idx, mem_data,
        input flush
    );

endinterface

// File: src/issue_if.sv
`timescale 1ns/100ps

interface issue_if;
    import lsq_pkg::*;

    // offer from the queue, taken when both valid and ready
    logic       req_valid;
    logic       req_ready;
    lsq_entry_t req_entry;

    // one cycle pulse when a store write is done
    logic       st_done;

    modport queue (
        output req_valid, req_entry,
        input  req_ready, st_done
    );

    modport mem (
        output req_ready, st_done,
        input  req_valid, req_entry
    );

endinterface

// File: src/lsq_queue.sv
`timescale 1ns/100ps
`include "lsq_defs.svh"

module lsq_queue #(
    parameter int DEPTH = `LSQ_DEPTH
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  disp_valid,
    input  lsq_pkg::mem_op_e      disp_op,
    input  logic [`ROB_IDX_W-1:0] disp_rob_idx,
    input  logic [`ROB_IDX_W-1:0] disp_rs1_tag,
    input  logic                  disp_rs1_ready,
    input  logic [`XLEN-1:0]      disp_rs1_data,
    input  logic [`ROB_IDX_W-1:0] disp_rs2_tag,
    input  logic                  disp_rs2_ready,
    input  logic [`XLEN-1:0]      disp_rs2_data,
    input  logic [`XLEN-1:0]      disp_imm,
    output logic                  disp_ready,
    input  logic                  commit_valid,
    input  logic [`ROB_IDX_W-1:0] commit_rob_idx,
    cdb_if.listener               cdb,
    issue_if.queue                iss
);
    import lsq_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    lsq_entry_t       ld_q   [DEPTH];
    lsq_entry_t       ld_nxt [DEPTH];
    lsq_entry_t       st_q   [DEPTH];
    lsq_entry_t       st_nxt [DEPTH];
    logic [PTR_W-1:0] st_head, st_head_nxt;
    logic [PTR_W-1:0] st_tail, st_tail_nxt;
    logic [CNT_W-1:0] st_cnt, st_cnt_nxt;
    logic [PTR_W-1:0] ld_free_idx;
    logic [PTR_W-1:0] ld_sel;
    logic             ld_has_free;
    logic             ld_found;
    logic             st_offer;
    logic             disp_fire, disp_ld, disp_st;
    logic             xfer_ld;
    lsq_entry_t       disp_ent;
    lsq_entry_t       new_ent;

    // both producers on the result bus
    function automatic lsq_entry_t wake(input lsq_entry_t e);
        lsq_entry_t r;
        r = e;
        if (!e.rs1_ready && cdb.ext_valid && cdb.ext_rob_idx == e.rs1_tag) begin
            r.rs1_data  = cdb.ext_data;
            r.rs1_ready = 1'b1;
        end else if (!e.rs1_ready && cdb.mem_valid && cdb.mem_rob_idx == e.rs1_tag) begin
            r.rs1_data  = cdb.mem_data;
            r.rs1_ready = 1'b1;
        end
        if (!e.rs2_ready && cdb.ext_valid && cdb.ext_rob_idx == e.rs2_tag) begin
            r.rs2_data  = cdb.ext_data;
            r.rs2_ready = 1'b1;
        end else if (!e.rs2_ready && cdb.mem_valid && cdb.mem_rob_idx == e.rs2_tag) begin
            r.rs2_data  = cdb.mem_data;
            r.rs2_ready = 1'b1;
        end
        return r;
    endfunction

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // lowest free load slot and lowest ready load
    always_comb begin
        ld_has_free = 1'b0;
        ld_free_idx = '0;
        ld_found    = 1'b0;
        ld_sel      = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!ld_q[i].valid) begin
                ld_has_free = 1'b1;
                ld_free_idx = PTR_W'(i);
            end
            if (ld_q[i].valid && !ld_q[i].issued && ld_q[i].rs1_ready &&
                ld_q[i].older_stores == '0) begin
                ld_found = 1'b1;
                ld_sel   = PTR_W'(i);
            end
        end
    end

    // store head goes first, and only once committed
    assign st_offer = st_q[st_head].valid && st_q[st_head].committed &&
                      st_q[st_head].rs1_ready && st_q[st_head].rs2_ready;

    assign iss.req_valid = st_offer || ld_found;
    assign iss.req_entry = st_offer ? st_q[st_head] : ld_q[ld_sel];

    assign xfer_ld    = iss.req_valid && iss.req_ready && !st_offer;
    assign disp_ready = ld_has_free && (st_cnt != CNT_W'(DEPTH));
    assign disp_fire  = disp_valid && disp_ready;
    assign disp_ld    = disp_fire && (disp_op == MEM_LOAD);
    assign disp_st    = disp_fire && (disp_op == MEM_STORE);

    always_comb begin
        disp_ent              = '0;
        disp_ent.valid        = 1'b1;
        disp_ent.op           = disp_op;
        disp_ent.rob_idx      = disp_rob_idx;
        disp_ent.rs1_tag      = disp_rs1_tag;
        disp_ent.rs1_ready    = disp_rs1_ready;
        disp_ent.rs1_data     = disp_rs1_data;
        disp_ent.rs2_tag      = disp_rs2_tag;
        disp_ent.rs2_ready    = disp_rs2_ready;
        disp_ent.rs2_data     = disp_rs2_data;
        disp_ent.imm          = disp_imm;
        // stores still pending after this edge
        if (disp_op == MEM_LOAD) begin
            disp_ent.older_stores = OS_W'(st_cnt - CNT_W'(iss.st_done));
        end
        new_ent = wake(disp_ent);
    end

    always_comb begin
        st_head_nxt = st_head;
        st_tail_nxt = st_tail;
        st_cnt_nxt  = st_cnt;
        for (int i = 0; i < DEPTH; i++) begin
            ld_nxt[i] = wake(ld_q[i]);
            if (iss.st_done && ld_q[i].older_stores != '0) begin
                ld_nxt[i].older_stores = ld_q[i].older_stores - 1'b1;
            end
            if (xfer_ld && ld_sel == PTR_W'(i)) begin
                ld_nxt[i].issued = 1'b1;
            end
            // load result seen on the bus frees the slot
            if (ld_q[i].valid && ld_q[i].issued && cdb.mem_valid &&
                cdb.mem_rob_idx == ld_q[i].rob_idx) begin
                ld_nxt[i].valid = 1'b0;
            end
            if (disp_ld && ld_free_idx == PTR_W'(i)) begin
                ld_nxt[i] = new_ent;
            end

            st_nxt[i] = wake(st_q[i]);
            if (commit_valid && st_q[i].valid && commit_rob_idx == st_q[i].rob_idx) begin
                st_nxt[i].committed = 1'b1;
            end
            if (iss.st_done && st_head == PTR_W'(i)) begin
                st_nxt[i].valid = 1'b0;
            end
            if (disp_st && st_tail == PTR_W'(i)) begin
                st_nxt[i] = new_ent;
            end
        end
        if (iss.st_done) begin
            st_head_nxt = ptr_inc(st_head);
            st_cnt_nxt  = st_cnt_nxt - 1'b1;
        end
        if (disp_st) begin
            st_tail_nxt = ptr_inc(st_tail);
            st_cnt_nxt  = st_cnt_nxt + 1'b1;
        end
        // flush empties both queues
        if (cdb.flush) begin
            for (int i = 0; i < DEPTH; i++) begin
                ld_nxt[i].valid = 1'b0;
                st_nxt[i].valid = 1'b0;
            end
            st_head_nxt = '0;
            st_tail_nxt = '0;
            st_cnt_nxt  = '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ld_q    <= '{default: '0};
            st_q    <= '{default: '0};
            st_head <= '0;
            st_tail <= '0;
            st_cnt  <= '0;
        end else begin
            ld_q    <= ld_nxt;
            st_q    <= st_nxt;
            st_head <= st_head_nxt;
            st_tail <= st_tail_nxt;
            st_cnt  <= st_cnt_nxt;
        end
    end

endmodule

// File: src/mem_unit.sv
`timescale 1ns/100ps
`include "lsq_defs.svh"

module mem_unit (
    input  logic             clk,
    input  logic             arst_n,
    issue_if.mem             iss,
    cdb_if.mem_src           cdb,
    output logic             psel,
    output logic             penable,
    output logic             pwrite,
    output logic [`XLEN-1:0] paddr,
    output logic [`XLEN-1:0] pwdata,
    input  logic [`XLEN-1:0] prdata,
    input  logic             pready
);
    import lsq_pkg::*;

    mu_state_e        state;
    lsq_entry_t       ent_q;
    logic [`XLEN-1:0] addr_q;
    logic [`XLEN-1:0] rdata_q;
    // transfer outlives a flush, its result does not
    logic             killed;
    logic             xfer;

    assign iss.req_ready = (state == MU_IDLE) && !cdb.flush;
    assign xfer          = iss.req_valid && iss.req_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= MU_IDLE;
            killed <= 1'b0;
        end else begin
            case (state)
                MU_IDLE: begin
                    if (xfer) begin
                        state <= MU_SETUP;
                    end
                end
                MU_SETUP: begin
                    state <= cdb.flush ? MU_IDLE : MU_ACCESS;
                end
                MU_ACCESS: begin
                    if (pready) begin
                        state  <= (killed || cdb.flush) ? MU_IDLE : MU_RESULT;
                        killed <= 1'b0;
                    end else if (cdb.flush) begin
                        killed <= 1'b1;
                    end
                end
                default: begin
                    state <= MU_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            ent_q  <= iss.req_entry;
            addr_q <= iss.req_entry.rs1_data + iss.req_entry.imm;
        end
        if (state == MU_ACCESS && pready) begin
            rdata_q <= prdata;
        end
    end

    assign psel    = (state == MU_SETUP) || (state == MU_ACCESS);
    assign penable = (state == MU_ACCESS);
    assign pwrite  = (ent_q.op == MEM_STORE);
    assign paddr   = addr_q;
    assign pwdata  = ent_q.rs2_data;

    // one result cycle, load data or store done
    assign cdb.mem_valid   = (state == MU_RESULT) && (ent_q.op == MEM_LOAD) && !cdb.flush;
    assign cdb.mem_rob_idx = ent_q.rob_idx;
    assign cdb.mem_data    = rdata_q;
    assign iss.st_done     = (state == MU_RESULT) && (ent_q.op == MEM_STORE) && !cdb.flush;

endmodule

// File: src/dmem_apb.sv
`timescale 1ns/100ps
`include "lsq_defs.svh"

module dmem_apb #(
    parameter int WORDS = `DMEM_WORDS
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  logic [`XLEN-1:0] paddr,
    input  logic [`XLEN-1:0] pwdata,
    output logic [`XLEN-1:0] prdata,
    output logic             pready
);
    localparam int IDX_W  = (WORDS > 1) ? $clog2(WORDS) : 1;
    localparam int WAIT_W = $clog2(`DMEM_WAIT + 2);

    logic [`XLEN-1:0]  mem [WORDS];
    logic [IDX_W-1:0]  word_idx;
    logic [WAIT_W-1:0] wait_cnt;

    // word address, byte offset dropped
    assign word_idx = IDX_W'(paddr[`XLEN-1:2] % WORDS);

    assign pready = psel && penable && (wait_cnt == WAIT_W'(`DMEM_WAIT));
    assign prdata = mem[word_idx];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wait_cnt <= '0;
        end else if (psel && penable && !pready) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (psel && penable && pready && pwrite) begin
            mem[word_idx] <= pwdata;
        end
    end

endmodule

// File: src/lsq_top.sv
`timescale 1ns/100ps
`include "lsq_defs.svh"

module lsq_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  disp_valid,
    input  lsq_pkg::mem_op_e      disp_op,
    input  logic [`ROB_IDX_W-1:0] disp_rob_idx,
    input  logic [`ROB_IDX_W-1:0] disp_rs1_tag,
    input  logic                  disp_rs1_ready,
    input  logic [`XLEN-1:0]      disp_rs1_data,
    input  logic [`ROB_IDX_W-1:0] disp_rs2_tag,
    input  logic                  disp_rs2_ready,
    input  logic [`XLEN-1:0]      disp_rs2_data,
    input  logic [`XLEN-1:0]      disp_imm,
    output logic                  disp_ready,
    input  logic                  commit_valid,
    input  logic [`ROB_IDX_W-1:0] commit_rob_idx,
    input  logic                  ext_valid,
    input  logic [`ROB_IDX_W-1:0] ext_rob_idx,
    input  logic [`XLEN-1:0]      ext_data,
    input  logic                  flush,
    output logic                  ld_wb_valid,
    output logic [`ROB_IDX_W-1:0] ld_wb_rob_idx,
    output logic [`XLEN-1:0]      ld_wb_data,
    output logic                  st_done_valid,
    output logic [`ROB_IDX_W-1:0] st_done_rob_idx
);
    logic             psel;
    logic             penable;
    logic             pwrite;
    logic [`XLEN-1:0] paddr;
    logic [`XLEN-1:0] pwdata;
    logic [`XLEN-1:0] prdata;
    logic             pready;

    cdb_if   u_cdb ();
    issue_if u_iss ();

    assign u_cdb.ext_valid   = ext_valid;
    assign u_cdb.ext_rob_idx = ext_rob_idx;
    assign u_cdb.ext_data    = ext_data;
    assign u_cdb.flush       = flush;

    lsq_queue u_queue (
        .clk, .arst_n,
        .disp_valid, .disp_op, .disp_rob_idx,
        .disp_rs1_tag, .disp_rs1_ready, .disp_rs1_data,
        .disp_rs2_tag, .disp_rs2_ready, .disp_rs2_data,
        .disp_imm, .disp_ready,
        .commit_valid, .commit_rob_idx,
        .cdb (u_cdb.listener),
        .iss (u_iss.queue)
    );

    mem_unit u_mem (
        .clk, .arst_n,
        .iss (u_iss.mem),
        .cdb (u_cdb.mem_src),
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready
    );

    dmem_apb u_dmem (
        .clk, .arst_n,
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready
    );

    // writeback mirrors the memory result channel
    assign ld_wb_valid     = u_cdb.mem_valid;
    assign ld_wb_rob_idx   = u_cdb.mem_rob_idx;
    assign ld_wb_data      = u_cdb.mem_data;
    assign st_done_valid   = u_iss.st_done;
    assign st_done_rob_idx = u_cdb.mem_rob_idx;

endmodule

// File: dv/lsq_props.sv
`timescale 1ns/100ps
`include "lsq_defs.svh"

module lsq_props (
    input logic                  clk,
    input logic                  arst_n,
    input logic                  psel,
    input logic                  penable,
    input logic [`XLEN-1:0]      paddr,
    input logic                  flush,
    input logic                  disp_valid,
    input logic                  disp_ready,
    input lsq_pkg::mem_op_e      disp_op,
    input logic [`ROB_IDX_W-1:0] disp_rob_idx,
    input logic                  ld_wb_valid,
    input logic [`ROB_IDX_W-1:0] ld_wb_rob_idx,
    input logic                  st_done_valid
);
    import lsq_pkg::*;

    localparam int N_ROB = 1 << `ROB_IDX_W;

    int fail_cnt = 0;

    // stores dispatched and not yet done, and what each load saw at dispatch
    logic [OS_W-1:0] st_pend;
    logic [OS_W-1:0] ld_wait [N_ROB];
    logic            disp_fire;
    // cycles since the last flush, saturating
    logic [2:0]      since_flush;

    assign disp_fire = disp_valid && disp_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            st_pend <= '0;
            ld_wait <= '{default: '0};
        end else if (flush) begin
            st_pend <= '0;
            ld_wait <= '{default: '0};
        end else begin
            for (int i = 0; i < N_ROB; i++) begin
                if (st_done_valid && ld_wait[i] != '0) begin
                    ld_wait[i] <= ld_wait[i] - 1'b1;
                end
            end
            if (disp_fire && disp_op == MEM_LOAD) begin
                ld_wait[disp_rob_idx] <= st_pend - OS_W'(st_done_valid);
            end
            st_pend <= st_pend + OS_W'(disp_fire && disp_op == MEM_STORE)
                       - OS_W'(st_done_valid);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            since_flush <= '1;
        end else if (flush) begin
            since_flush <= '0;
        end else if (since_flush != '1) begin
            since_flush <= since_flush + 1'b1;
        end
    end

    // access phase follows the setup cycle unless a flush drops it
    a_setup_then_access: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(psel) && !flush |=> penable)
        else begin
            fail_cnt++;
            $error("apb setup cycle not followed by access");
        end

    a_access_has_setup: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(penable) |-> $past(psel) && !$past(penable))
        else begin
            fail_cnt++;
            $error("apb access without a setup cycle");
        end

    a_addr_stable: assert property (@(posedge clk) disable iff (!arst_n)
        penable |-> $stable(paddr))
        else begin
            fail_cnt++;
            $error("apb address changed during a transfer");
        end

    a_one_result: assert property (@(posedge clk) disable iff (!arst_n)
        !(ld_wb_valid && st_done_valid))
        else begin
            fail_cnt++;
            $error("load writeback and store done in the same cycle");
        end

    // an operation in flight at a flush never writes back
    a_flush_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        ld_wb_valid |-> !flush && since_flush > 3'(`DMEM_WAIT + 1))
        else begin
            fail_cnt++;
            $error("load writeback from an operation that was flushed");
        end

    // a load writes back only with no older store pending
    a_load_order: assert property (@(posedge clk) disable iff (!arst_n)
        ld_wb_valid |-> ld_wait[ld_wb_rob_idx] == '0)
        else begin
            fail_cnt++;
            $error("load wrote back while an older store is pending");
        end

endmodule

bind lsq_top lsq_props u_props (
    .clk           (clk),
    .arst_n        (arst_n),
    .psel          (psel),
    .penable       (penable),
    .paddr         (paddr),
    .flush         (flush),
    .disp_valid    (disp_valid),
    .disp_ready    (disp_ready),
    .disp_op       (disp_op),
    .disp_rob_idx  (disp_rob_idx),
    .ld_wb_valid   (ld_wb_valid),
    .ld_wb_rob_idx (ld_wb_rob_idx),
    .st_done_valid (st_done_valid)
);

// File: dv/lsq_tb.sv
`timescale 1ns/100ps
`include "lsq_defs.svh"

module lsq_tb;
    import lsq_pkg::*;

    localparam int TMO = 400;

    logic                  clk;
    logic                  arst_n;
    logic                  disp_valid;
    mem_op_e               disp_op;
    logic [`ROB_IDX_W-1:0] disp_rob_idx;
    logic [`ROB_IDX_W-1:0] disp_rs1_tag;
    logic                  disp_rs1_ready;
    logic [`XLEN-1:0]      disp_rs1_data;
    logic [`ROB_IDX_W-1:0] disp_rs2_tag;
    logic                  disp_rs2_ready;
    logic [`XLEN-1:0]      disp_rs2_data;
    logic [`XLEN-1:0]      disp_imm;
    logic                  disp_ready;
    logic                  commit_valid;
    logic [`ROB_IDX_W-1:0] commit_rob_idx;
    logic                  ext_valid;
    logic [`ROB_IDX_W-1:0] ext_rob_idx;
    logic [`XLEN-1:0]      ext_data;
    logic                  flush;
    logic                  ld_wb_valid;
    logic [`ROB_IDX_W-1:0] ld_wb_rob_idx;
    logic [`XLEN-1:0]      ld_wb_data;
    logic                  st_done_valid;
    logic [`ROB_IDX_W-1:0] st_done_rob_idx;

    // reference memory and expected results by rob index
    logic [`XLEN-1:0]      ref_mem [`DMEM_WORDS];
    logic [`XLEN-1:0]      exp_data [32];
    bit                    pend [32];
    bit                    hold [32];
    logic [`ROB_IDX_W-1:0] exp_st [$];
    int                    n_pend = 0;
    int                    n_mismatch = 0;
    int                    n_other = 0;
    int                    rob_ctr = 0;
    integer                seed;
    string                 test_name;

    lsq_top u_lsq_top (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int word_of(input logic [`XLEN-1:0] addr);
        return int'((addr >> 2) % `DMEM_WORDS);
    endfunction

    // tags 28 to 31 are kept for wakeup tests
    function automatic logic [`ROB_IDX_W-1:0] next_rob();
        rob_ctr = (rob_ctr + 1) % 28;
        return `ROB_IDX_W'(rob_ctr);
    endfunction

    task automatic dispatch_op(input mem_op_e op, input logic [`ROB_IDX_W-1:0] rob,
                               input logic [`ROB_IDX_W-1:0] tag, input logic rdy,
                               input logic [`XLEN-1:0] base, input logic [`XLEN-1:0] imm,
                               input logic [`XLEN-1:0] data);
        int n;
        n = 0;
        @(negedge clk);
        disp_valid     = 1'b1;
        disp_op        = op;
        disp_rob_idx   = rob;
        disp_rs1_tag   = tag;
        disp_rs1_ready = rdy;
        disp_rs1_data  = base;
        disp_rs2_data  = data;
        disp_imm       = imm;
        @(posedge clk);
        while (!disp_ready && n < TMO) begin
            @(posedge clk);
            n++;
        end
        assert (disp_ready) else begin
            n_other++;
            $display("Error in %s: dispatch of rob %0d was never accepted", test_name, rob);
        end
        @(negedge clk);
        disp_valid = 1'b0;
    endtask

    task automatic store_word(input logic [`XLEN-1:0] base, input logic [`XLEN-1:0] imm,
                              input logic [`XLEN-1:0] data,
                              output logic [`ROB_IDX_W-1:0] rob);
        rob = next_rob();
        ref_mem[word_of(base + imm)] = data;
        exp_st.push_back(rob);
        dispatch_op(MEM_STORE, rob, '0, 1'b1, base, imm, data);
    endtask

    // an unready base goes in inverted, the real value comes by broadcast
    task automatic load_word(input logic [`XLEN-1:0] base, input logic [`XLEN-1:0] imm,
                             input logic rdy, input logic [`ROB_IDX_W-1:0] tag,
                             input bit held, output logic [`ROB_IDX_W-1:0] rob);
        rob = next_rob();
        exp_data[rob] = ref_mem[word_of(base + imm)];
        pend[rob]     = 1'b1;
        hold[rob]     = held;
        n_pend++;
        dispatch_op(MEM_LOAD, rob, tag, rdy, rdy ? base : ~base, imm, '0);
    endtask

    task automatic commit_store(input logic [`ROB_IDX_W-1:0] rob);
        @(negedge clk);
        commit_valid   = 1'b1;
        commit_rob_idx = rob;
        @(negedge clk);
        commit_valid = 1'b0;
    endtask

    task automatic broadcast(input logic [`ROB_IDX_W-1:0] tag, input logic [`XLEN-1:0] data);
        @(negedge clk);
        ext_valid   = 1'b1;
        ext_rob_idx = tag;
        ext_data    = data;
        @(negedge clk);
        ext_valid = 1'b0;
    endtask

    task automatic wait_done(input bit loads, input bit stores);
        int n;
        n = 0;
        while (((loads && n_pend != 0) || (stores && exp_st.size() != 0)) && n < TMO) begin
            @(negedge clk);
            n++;
        end
        assert (!((loads && n_pend != 0) || (stores && exp_st.size() != 0))) else begin
            n_other++;
            $display("Error in %s: timed out waiting for outstanding results", test_name);
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge clk);
    endtask

    // results are checked against the expected set as they appear
    always @(posedge clk) begin
        if (arst_n && ld_wb_valid) begin
            assert (pend[ld_wb_rob_idx]) else begin
                n_other++;
                $display("Error in %s: writeback for rob %0d which is not pending",
                         test_name, ld_wb_rob_idx);
            end
            if (pend[ld_wb_rob_idx]) begin
                assert (!hold[ld_wb_rob_idx]) else begin
                    n_other++;
                    $display("Error in %s: rob %0d wrote back while it should still wait",
                             test_name, ld_wb_rob_idx);
                end
                assert (ld_wb_data == exp_data[ld_wb_rob_idx]) else begin
                    n_mismatch++;
                    $display("Mismatch in %s: rob %0d load data expected %h actual %h",
                             test_name, ld_wb_rob_idx, exp_data[ld_wb_rob_idx], ld_wb_data);
                end
                pend[ld_wb_rob_idx] = 1'b0;
                n_pend--;
            end
        end
        if (arst_n && st_done_valid) begin
            assert (exp_st.size() != 0) else begin
                n_other++;
                $display("Error in %s: store done with no store outstanding", test_name);
            end
            if (exp_st.size() != 0) begin
                assert (st_done_rob_idx == exp_st[0]) else begin
                    n_mismatch++;
                    $display("Mismatch in %s: store done rob expected %0d actual %0d",
                             test_name, exp_st[0], st_done_rob_idx);
                end
                void'(exp_st.pop_front());
            end
        end
    end

    initial begin
        logic [`ROB_IDX_W-1:0] r1;
        logic [`ROB_IDX_W-1:0] r2;
        logic [`XLEN-1:0]      a;
        int                    n;
        seed           = 22;
        test_name      = "reset";
        arst_n         = 1'b0;
        disp_valid     = 1'b0;
        disp_op        = MEM_LOAD;
        disp_rob_idx   = '0;
        disp_rs1_tag   = '0;
        disp_rs1_ready = 1'b0;
        disp_rs1_data  = '0;
        disp_rs2_tag   = '0;
        disp_rs2_ready = 1'b1;
        disp_rs2_data  = '0;
        disp_imm       = '0;
        commit_valid   = 1'b0;
        commit_rob_idx = '0;
        ext_valid      = 1'b0;
        ext_rob_idx    = '0;
        ext_data       = '0;
        flush          = 1'b0;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        @(posedge clk);
        assert (disp_ready && !ld_wb_valid && !st_done_valid) else begin
            n_other++;
            $display("Error: outputs not idle after reset");
        end

        // every word gets a defined value first
        test_name = "fill";
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            store_word(32'(i * 4), '0, $random(seed), r1);
            commit_store(r1);
        end
        wait_done(1'b1, 1'b1);

        // 0x124 and 0x127 share word 73 mod 64
        test_name = "store_then_load";
        store_word(32'h100, 32'h24, $random(seed), r1);
        commit_store(r1);
        load_word(32'h120, 32'h7, 1'b1, '0, 1'b0, r2);
        wait_done(1'b1, 1'b1);

        test_name = "operand_wakeup";
        load_word(32'h30, 32'h4, 1'b0, 5'd29, 1'b1, r1);
        idle(10);
        hold[r1] = 1'b0;
        broadcast(5'd29, 32'h30);
        wait_done(1'b1, 1'b0);

        test_name = "load_after_store";
        store_word(32'h80, '0, $random(seed), r1);
        load_word(32'h80, '0, 1'b1, '0, 1'b1, r2);
        idle(10);
        commit_store(r1);
        wait_done(1'b0, 1'b1);
        hold[r2] = 1'b0;
        wait_done(1'b1, 1'b0);

        test_name = "loads_out_of_order";
        load_word(32'h44, 32'h8, 1'b0, 5'd30, 1'b1, r1);
        load_word(32'h10, 32'hc, 1'b1, '0, 1'b0, r2);
        n = 0;
        while (pend[r2] && n < TMO) begin
            @(negedge clk);
            n++;
        end
        assert (!pend[r2] && pend[r1]) else begin
            n_other++;
            $display("Error in %s: younger load did not finish ahead of the waiting one",
                     test_name);
        end
        hold[r1] = 1'b0;
        broadcast(5'd30, 32'h44);
        wait_done(1'b1, 1'b0);

        // these loads are never expected back, the last one is ready and caught in flight
        test_name = "full_queue_flush";
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            dispatch_op(MEM_LOAD, next_rob(), 5'd31, i == `LSQ_DEPTH - 1, '0, '0, '0);
        end
        @(posedge clk);
        assert (disp_ready == 1'b0) else begin
            n_mismatch++;
            $display("Mismatch in %s: disp_ready expected 0 actual %b", test_name, disp_ready);
        end
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        @(posedge clk);
        assert (disp_ready == 1'b1) else begin
            n_mismatch++;
            $display("Mismatch in %s: disp_ready expected 1 actual %b", test_name, disp_ready);
        end
        idle(20);

        // loads drain before a store so no younger store overtakes them
        test_name = "random_mix";
        for (int i = 0; i < 80; i++) begin
            a = $random(seed);
            if (a[0]) begin
                wait_done(1'b1, 1'b0);
                store_word($random(seed), $random(seed) & 32'hfff, $random(seed), r1);
                commit_store(r1);
            end else begin
                load_word($random(seed), $random(seed) & 32'hfff, 1'b1, '0, 1'b0, r1);
            end
        end
        wait_done(1'b1, 1'b1);
        idle(5);

        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 n_mismatch, n_other, u_lsq_top.u_props.fail_cnt);
        if (n_mismatch == 0 && n_other == 0 && u_lsq_top.u_props.fail_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+src
src/lsq_pkg.sv
src/cdb_if.sv
src/issue_if.sv
src/lsq_queue.sv
src/mem_unit.sv
src/dmem_apb.sv
src/lsq_top.sv
dv/lsq_props.sv
dv/lsq_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module lsq_tb -f compile.f -o lsq_sim

# a high error limit lets the run reach its closing summary
./obj_dir/lsq_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test completed successfully$" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
